// ==== rtl/cfg_arbiter.sv ====
`timescale 1ns/1ps

module cfg_arbiter (
    input  logic clk,
    input  logic n_rst,
    input  logic [switch_pkg::NUM_INPORTS-1:0] cfg_req,
    input  chiplet_types_pkg::flit_t cfg_flit_0,
    input  chiplet_types_pkg::flit_t cfg_flit_1,
    output logic [switch_pkg::NUM_INPORTS-1:0] cfg_grant,
    output logic wr_valid,
    output chiplet_types_pkg::flit_t wr_flit
);
    import chiplet_types_pkg::*;
    import switch_pkg::*;

    logic [PORT_IDX_W-1:0] last_grant;
    logic [PORT_IDX_W-1:0] grant_idx;

    // search starts one past the last winner
    always_comb begin
        int  idx;
        logic found;
        cfg_grant = '0;
        grant_idx = last_grant;
        found     = 1'b0;
        for (int i = 1; i <= NUM_INPORTS; i++) begin
            idx = (int'(last_grant) + i) % NUM_INPORTS;
            if (!found && cfg_req[idx]) begin
                cfg_grant[idx] = 1'b1;
                grant_idx      = idx[PORT_IDX_W-1:0];
                found          = 1'b1;
            end
        end
    end

    assign wr_valid = |cfg_grant;
    assign wr_flit  = (grant_idx == PORT_IDX_W'(1)) ? cfg_flit_1 : cfg_flit_0;

    // reset value gives port 0 the first turn
    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            last_grant <= PORT_IDX_W'(NUM_INPORTS - 1);
        end else if (wr_valid) begin
            last_grant <= grant_idx;
        end
    end

endmodule

// ==== rtl/chiplet_types_pkg.sv ====
package chiplet_types_pkg;

    // flit word
    localparam int FLIT_W = 32;
    typedef logic [FLIT_W-1:0] flit_t;

    // format field sits in the top nibble of every flit
    localparam int FMT_LSB = 28;
    localparam int FMT_W   = 4;

    typedef enum logic [FMT_W-1:0] {
        FMT_IDLE       = 4'h0,
        FMT_DATA       = 4'h1,
        FMT_SWITCH_CFG = 4'h2
    } flit_fmt_e;

    // node ids
    localparam int NODE_ID_W = 5;
    typedef logic [NODE_ID_W-1:0] node_id_t;

    // data flit, destination in bits 27:23
    localparam int DEST_LSB = 23;

    // config flit, address in bits 27:20 and data in bits 14:0
    localparam int CFG_ADDR_LSB = 20;
    localparam int CFG_ADDR_W   = 8;
    localparam int CFG_DATA_W   = 15;

endpackage

// ==== rtl/ingress_port.sv ====
`timescale 1ns/1ps

module ingress_port (
    input  logic clk,
    input  logic n_rst,
    input  logic in_valid,
    input  chiplet_types_pkg::flit_t in_flit,
    input  logic cfg_grant,
    output logic cfg_req,
    output chiplet_types_pkg::flit_t cfg_flit,
    input  switch_pkg::route_lut_t [switch_pkg::TABLE_SIZE-1:0] route_lut,
    input  logic [switch_pkg::NUM_OUTPORTS-1:0] dateline,
    input  chiplet_types_pkg::node_id_t node_id,
    input  logic config_done,
    output logic route_valid,
    output logic [switch_pkg::OUTPORT_W-1:0] route_outport,
    output logic route_vc,
    output logic route_drop
);
    import chiplet_types_pkg::*;
    import switch_pkg::*;

    flit_fmt_e in_fmt;
    node_id_t  dest;

    logic     hit;
    outport_t hit_port;

    outport_t next_outport;
    logic     next_vc;
    logic     next_drop;

    assign in_fmt = flit_fmt_e'(in_flit[FMT_LSB +: FMT_W]);
    assign dest   = in_flit[DEST_LSB +: NODE_ID_W];

    // pending config slot, held until the arbiter grants it
    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            cfg_req <= 1'b0;
        end else if (in_valid && in_fmt == FMT_SWITCH_CFG) begin
            cfg_req <= 1'b1;
        end else if (cfg_grant) begin
            cfg_req <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_fmt == FMT_SWITCH_CFG) begin
            cfg_flit <= in_flit;
        end
    end

    // priority search, lowest index wins
    always_comb begin
        hit      = 1'b0;
        hit_port = LOCAL_PORT;
        for (int i = 0; i < TABLE_SIZE; i++) begin
            if (!hit && route_lut[i].node_lo <= dest && dest <= route_lut[i].node_hi) begin
                hit      = 1'b1;
                hit_port = route_lut[i].outport;
            end
        end
    end

    always_comb begin
        if (!config_done) begin
            next_outport = '0; // not configured yet, drop everything
            next_vc      = 1'b0;
            next_drop    = 1'b1;
        end else if (dest == node_id) begin
            next_outport = LOCAL_PORT;
            next_vc      = 1'b0;
            next_drop    = 1'b0;
        end else if (hit) begin
            next_outport = hit_port;
            next_vc      = dateline[hit_port]; // vc flips across the dateline
            next_drop    = 1'b0;
        end else begin
            next_outport = '0;
            next_vc      = 1'b0;
            next_drop    = 1'b1;
        end
    end

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            route_valid   <= 1'b0;
            route_outport <= '0;
            route_vc      <= 1'b0;
            route_drop    <= 1'b0;
        end else begin
            route_valid <= in_valid && in_fmt == FMT_DATA;
            if (in_valid && in_fmt == FMT_DATA) begin
                route_outport <= next_outport;
                route_vc      <= next_vc;
                route_drop    <= next_drop;
            end
        end
    end

endmodule

// ==== rtl/switch_cfg_top.sv ====
`timescale 1ns/1ps

module switch_cfg_top (
    input  logic clk,
    input  logic n_rst,
    input  logic in_valid_0,
    input  chiplet_types_pkg::flit_t in_flit_0,
    input  logic in_valid_1,
    input  chiplet_types_pkg::flit_t in_flit_1,
    output logic route_valid_0,
    output logic [switch_pkg::OUTPORT_W-1:0] route_outport_0,
    output logic route_vc_0,
    output logic route_drop_0,
    output logic route_valid_1,
    output logic [switch_pkg::OUTPORT_W-1:0] route_outport_1,
    output logic route_vc_1,
    output logic route_drop_1,
    output logic config_done,
    output chiplet_types_pkg::node_id_t node_id
);
    import chiplet_types_pkg::*;
    import switch_pkg::*;

    // shared config write bus
    logic [NUM_INPORTS-1:0] cfg_req;
    logic [NUM_INPORTS-1:0] cfg_grant;
    flit_t                  cfg_flit_0;
    flit_t                  cfg_flit_1;
    logic                   wr_valid;
    flit_t                  wr_flit;

    // register bank broadcast
    route_lut_t [TABLE_SIZE-1:0] route_lut;
    logic [NUM_OUTPORTS-1:0]     dateline;

    ingress_port port0 (
        .clk           (clk),
        .n_rst         (n_rst),
        .in_valid      (in_valid_0),
        .in_flit       (in_flit_0),
        .cfg_grant     (cfg_grant[0]),
        .cfg_req       (cfg_req[0]),
        .cfg_flit      (cfg_flit_0),
        .route_lut     (route_lut),
        .dateline      (dateline),
        .node_id       (node_id),
        .config_done   (config_done),
        .route_valid   (route_valid_0),
        .route_outport (route_outport_0),
        .route_vc      (route_vc_0),
        .route_drop    (route_drop_0)
    );

    ingress_port port1 (
        .clk           (clk),
        .n_rst         (n_rst),
        .in_valid      (in_valid_1),
        .in_flit       (in_flit_1),
        .cfg_grant     (cfg_grant[1]),
        .cfg_req       (cfg_req[1]),
        .cfg_flit      (cfg_flit_1),
        .route_lut     (route_lut),
        .dateline      (dateline),
        .node_id       (node_id),
        .config_done   (config_done),
        .route_valid   (route_valid_1),
        .route_outport (route_outport_1),
        .route_vc      (route_vc_1),
        .route_drop    (route_drop_1)
    );

    cfg_arbiter arb (
        .clk        (clk),
        .n_rst      (n_rst),
        .cfg_req    (cfg_req),
        .cfg_flit_0 (cfg_flit_0),
        .cfg_flit_1 (cfg_flit_1),
        .cfg_grant  (cfg_grant),
        .wr_valid   (wr_valid),
        .wr_flit    (wr_flit)
    );

    switch_reg_bank reg_bank (
        .clk         (clk),
        .n_rst       (n_rst),
        .wr_valid    (wr_valid),
        .wr_flit     (wr_flit),
        .route_lut   (route_lut),
        .dateline    (dateline),
        .node_id     (node_id),
        .config_done (config_done)
    );

endmodule

// ==== rtl/switch_pkg.sv ====
package switch_pkg;

    // switch sizes
    localparam int NUM_INPORTS  = 2;
    localparam int NUM_OUTPORTS = 4;
    localparam int TABLE_SIZE   = 17;

    localparam int PORT_IDX_W = $clog2(NUM_INPORTS);
    localparam int OUTPORT_W  = $clog2(NUM_OUTPORTS);
    localparam int LUT_IDX_W  = $clog2(TABLE_SIZE);

    // register map, table entries occupy 8'h00 up to LUT_TOP_ADDR
    localparam logic [7:0] LUT_TOP_ADDR  = 8'h10;
    localparam logic [7:0] DATELINE_ADDR = 8'h11;
    localparam logic [7:0] NODE_ID_ADDR  = 8'h12;
    localparam logic [7:0] CONFIG_ADDR   = 8'h13;

    typedef logic [OUTPORT_W-1:0] outport_t;

    // flits addressed to this switch leave here
    localparam outport_t LOCAL_PORT = outport_t'(0);

    // one route table entry, taken from config data bits 11:0
    typedef struct packed {
        chiplet_types_pkg::node_id_t node_lo;
        chiplet_types_pkg::node_id_t node_hi;
        outport_t                    outport;
    } route_lut_t;

    localparam int LUT_ENTRY_W = $bits(route_lut_t);

endpackage

// ==== rtl/switch_reg_bank.sv ====
`timescale 1ns/1ps

module switch_reg_bank (
    input  logic clk,
    input  logic n_rst,
    input  logic wr_valid,
    input  chiplet_types_pkg::flit_t wr_flit,
    output switch_pkg::route_lut_t [switch_pkg::TABLE_SIZE-1:0] route_lut,
    output logic [switch_pkg::NUM_OUTPORTS-1:0] dateline,
    output chiplet_types_pkg::node_id_t node_id,
    output logic config_done
);
    import chiplet_types_pkg::*;
    import switch_pkg::*;

    flit_fmt_e             wr_fmt;
    logic [CFG_ADDR_W-1:0] cfg_addr;
    logic [CFG_DATA_W-1:0] cfg_data;

    route_lut_t [TABLE_SIZE-1:0] next_route_lut;
    logic [NUM_OUTPORTS-1:0]     next_dateline;
    node_id_t                    next_node_id;
    logic                        next_config_done;

    assign wr_fmt   = flit_fmt_e'(wr_flit[FMT_LSB +: FMT_W]);
    assign cfg_addr = wr_flit[CFG_ADDR_LSB +: CFG_ADDR_W];
    assign cfg_data = wr_flit[CFG_DATA_W-1:0];

    always_comb begin
        next_route_lut   = route_lut;
        next_dateline    = dateline;
        next_node_id     = node_id;
        next_config_done = config_done;

        if (wr_valid && wr_fmt == FMT_SWITCH_CFG) begin
            if (cfg_addr <= LUT_TOP_ADDR) begin
                next_route_lut[cfg_addr[LUT_IDX_W-1:0]] = route_lut_t'(cfg_data[LUT_ENTRY_W-1:0]);
            end else if (cfg_addr == DATELINE_ADDR) begin
                next_dateline = cfg_data[NUM_OUTPORTS-1:0];
            end else if (cfg_addr == NODE_ID_ADDR) begin
                next_node_id = cfg_data[NODE_ID_W-1:0];
            end else if (cfg_addr == CONFIG_ADDR) begin
                next_config_done = cfg_data[0];
            end
            // 8'h14 and above fall through untouched
        end
    end

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            route_lut   <= '0;
            dateline    <= '0;
            node_id     <= '0;
            config_done <= 1'b0;
        end else begin
            route_lut   <= next_route_lut;
            dateline    <= next_dateline;
            node_id     <= next_node_id;
            config_done <= next_config_done;
        end
    end

endmodule

// ==== switch_cfg.f ====
rtl/chiplet_types_pkg.sv
rtl/switch_pkg.sv
rtl/ingress_port.sv
rtl/cfg_arbiter.sv
rtl/switch_reg_bank.sv
rtl/switch_cfg_top.sv
verification/switch_cfg_props.sv
verification/switch_cfg_tb.sv

// ==== verification/switch_cfg_props.sv ====
`timescale 1ns/1ps

module switch_cfg_props (
    input logic                                 clk,
    input logic                                 n_rst,
    input logic [switch_pkg::NUM_INPORTS-1:0]   cfg_req,
    input logic [switch_pkg::NUM_INPORTS-1:0]   cfg_grant,
    input logic                                 wr_valid,
    input chiplet_types_pkg::flit_t             wr_flit,
    input logic                                 config_done
);
    import chiplet_types_pkg::*;
    import switch_pkg::*;

    logic done_write; // bus write aimed at the config done register

    assign done_write = wr_valid && wr_flit[FMT_LSB +: FMT_W] == FMT_SWITCH_CFG
                        && wr_flit[CFG_ADDR_LSB +: CFG_ADDR_W] == CONFIG_ADDR;

    grant_onehot: assert property (@(posedge clk) disable iff (!n_rst) $onehot0(cfg_grant))
        else $error("cfg_grant is neither one-hot nor zero");

    // a pending request never waits on an idle bus
    wr_valid_granted: assert property (@(posedge clk) disable iff (!n_rst)
        wr_valid == |cfg_req)
        else $error("wr_valid does not match a granted request");

    // the port passed over on a collision wins the next cycle
    grant_alternates: assert property (@(posedge clk) disable iff (!n_rst)
        wr_valid && (cfg_req & ~cfg_grant) != '0 |=> cfg_grant == $past(cfg_req & ~cfg_grant))
        else $error("the waiting port was not granted after the other port");

    done_needs_write: assert property (@(posedge clk) disable iff (!n_rst)
        $rose(config_done) |-> $past(done_write))
        else $error("config_done rose without a write to its address");

endmodule

// arbiter and register bank nets inside the top level
bind switch_cfg_top switch_cfg_props props (
    .clk         (clk),
    .n_rst       (n_rst),
    .cfg_req     (cfg_req),
    .cfg_grant   (cfg_grant),
    .wr_valid    (wr_valid),
    .wr_flit     (wr_flit),
    .config_done (config_done)
);

// ==== verification/switch_cfg_tb.sv ====
`timescale 1ns/1ps

module switch_cfg_tb;
    import chiplet_types_pkg::*;
    import switch_pkg::*;

    localparam int RESET_CYCLES  = 16;
    localparam int RESET_TIMEOUT = 40;  // cycles allowed for reset release
    localparam int RUN_TIMEOUT   = 200; // cycles allowed for the whole trace
    localparam int NUM_EXPECT    = 10;

    logic                 clk;
    logic                 n_rst;
    logic                 in_valid_0;
    flit_t                in_flit_0;
    logic                 in_valid_1;
    flit_t                in_flit_1;
    logic                 route_valid_0;
    logic [OUTPORT_W-1:0] route_outport_0;
    logic                 route_vc_0;
    logic                 route_drop_0;
    logic                 route_valid_1;
    logic [OUTPORT_W-1:0] route_outport_1;
    logic                 route_vc_1;
    logic                 route_drop_1;
    logic                 config_done;
    node_id_t             node_id;

    integer seed = 32'hd64ee6de;
    logic   trace_done;
    int     line_no;
    string  exp_tok [NUM_EXPECT];

    switch_cfg_top dut (
        .clk             (clk),
        .n_rst           (n_rst),
        .in_valid_0      (in_valid_0),
        .in_flit_0       (in_flit_0),
        .in_valid_1      (in_valid_1),
        .in_flit_1       (in_flit_1),
        .route_valid_0   (route_valid_0),
        .route_outport_0 (route_outport_0),
        .route_vc_0      (route_vc_0),
        .route_drop_0    (route_drop_0),
        .route_valid_1   (route_valid_1),
        .route_outport_1 (route_outport_1),
        .route_vc_1      (route_vc_1),
        .route_drop_1    (route_drop_1),
        .config_done     (config_done),
        .node_id         (node_id)
    );

    always #50 clk = ~clk;

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Simulation finished: FAIL");
        $fatal(1, "simulation stopped");
    endtask

    // an expected value of x skips the compare
    task automatic check_value(input string name, input logic [31:0] actual,
                               input string expected);
        logic [31:0] want;
        if (expected != "x") begin
            want = expected.atohex();
            if (actual !== want) begin
                abort_run($sformatf("error: %s is 0x%0h, expected 0x%0h (trace line %0d)",
                                    name, actual, want, line_no));
            end
        end
    endtask

    // idle or undefined format, never data or config
    function automatic flit_t ignored_flit();
        flit_t f;
        f = $random(seed);
        if (f[FMT_LSB +: FMT_W] == FMT_DATA || f[FMT_LSB +: FMT_W] == FMT_SWITCH_CFG) begin
            f[FMT_LSB +: FMT_W] = FMT_IDLE;
        end
        return f;
    endfunction

    // mode 0 idle, 1 trace flit, 2 random ignored flit
    task automatic drive_inputs(input logic [1:0] mode_0, input flit_t flit_0,
                                input logic [1:0] mode_1, input flit_t flit_1);
        in_valid_0 = (mode_0 != 2'd0);
        in_flit_0  = (mode_0 == 2'd1) ? flit_0 : ignored_flit();
        in_valid_1 = (mode_1 != 2'd0);
        in_flit_1  = (mode_1 == 2'd1) ? flit_1 : ignored_flit();
    endtask

    task automatic check_outputs();
        check_value("route_valid_0", 32'(route_valid_0), exp_tok[0]);
        check_value("route_outport_0", 32'(route_outport_0), exp_tok[1]);
        check_value("route_vc_0", 32'(route_vc_0), exp_tok[2]);
        check_value("route_drop_0", 32'(route_drop_0), exp_tok[3]);
        check_value("route_valid_1", 32'(route_valid_1), exp_tok[4]);
        check_value("route_outport_1", 32'(route_outport_1), exp_tok[5]);
        check_value("route_vc_1", 32'(route_vc_1), exp_tok[6]);
        check_value("route_drop_1", 32'(route_drop_1), exp_tok[7]);
        check_value("config_done", 32'(config_done), exp_tok[8]);
        check_value("node_id", 32'(node_id), exp_tok[9]);
    endtask

    initial begin : trace_run
        int         fd;
        int         code;
        int         n;
        int         wait_cycles;
        logic       saw_end;
        string      line;
        string      first_tok;
        logic [1:0] mode_0;
        logic [1:0] mode_1;
        flit_t      flit_0;
        flit_t      flit_1;
        line_no = 0;
        fd = $fopen("verification/switch_cfg_trace.txt", "r");
        if (fd == 0) begin
            abort_run("cannot open the trace file verification/switch_cfg_trace.txt");
        end
        wait_cycles = 0;
        while (n_rst !== 1'b1) begin
            @(posedge clk);
            wait_cycles++;
            if (wait_cycles > RESET_TIMEOUT) begin
                abort_run("reset was not released within the timeout");
            end
        end
        saw_end = 1'b0;
        while (!saw_end) begin
            line = "";
            code = $fgets(line, fd);
            if (code == 0) begin
                abort_run("the trace file ended before its end marker");
            end
            line_no++;
            n = $sscanf(line, "%s", first_tok);
            if (n < 1 || first_tok[0] == "#") begin
                continue; // blank or comment
            end
            if (first_tok == "end") begin
                saw_end = 1'b1;
            end else begin
                n = $sscanf(line, "%h %h %h %h %s %s %s %s %s %s %s %s %s %s",
                            mode_0, flit_0, mode_1, flit_1,
                            exp_tok[0], exp_tok[1], exp_tok[2], exp_tok[3], exp_tok[4],
                            exp_tok[5], exp_tok[6], exp_tok[7], exp_tok[8], exp_tok[9]);
                if (n != 14) begin
                    abort_run($sformatf("trace line %0d holds %0d fields instead of 14",
                                        line_no, n));
                end
                @(posedge clk);
                #5;
                drive_inputs(mode_0, flit_0, mode_1, flit_1);
                #90;
                check_outputs(); // just before the next edge
            end
        end
        $fclose(fd);
        trace_done = 1'b1;
    end

    initial begin : run_control
        int cycles;
        clk        = 1'b0;
        n_rst      = 1'b0;
        in_valid_0 = 1'b0;
        in_flit_0  = '0;
        in_valid_1 = 1'b0;
        in_flit_1  = '0;
        trace_done = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #5;
        n_rst = 1'b1;
        cycles = 0;
        while (!trace_done && cycles < RUN_TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        if (trace_done) begin
            $display("Simulation finished: PASS");
            $finish;
        end else begin
            abort_run("the trace did not complete within the timeout");
        end
    end

endmodule

// ==== verification/switch_cfg_trace.txt ====
# columns: mode0 flit0 mode1 flit1 | valid outport vc drop (port 0) | same for port 1 | done node_id
# mode 0 idle, 1 strobe flit, 2 strobe random ignored flit; expected in hex, x skips the check
# expected columns hold the responses to the flits of the line before
1 11000000 1 13800000   0 0 0 0   0 0 0 0   0 00
2 00000000 0 00000000   1 0 0 1   1 0 0 1   0 00
1 21200005 1 2110000a   0 x x x   0 x x x   0 00
0 00000000 2 00000000   0 x x x   0 x x x   0 00
1 20000091 1 201001aa   0 x x x   0 x x x   0 05
0 00000000 0 00000000   0 x x x   0 x x x   0 05
1 20200a7f 1 21407fff   0 x x x   0 x x x   0 05
1 11000000 1 17800000   0 x x x   0 x x x   0 05
1 21300001 0 00000000   1 0 0 1   1 0 0 1   0 05
0 00000000 0 00000000   0 x x x   0 x x x   0 05
1 12800000 1 11000000   0 x x x   0 x x x   1 05
1 13800000 1 1c800000   1 0 0 0   1 1 1 0   1 05
1 17800000 1 12000000   1 2 0 0   1 3 1 0   1 05
1 16000000 1 12800000   1 0 0 1   1 1 1 0   1 05
1 203005b9 1 203005ba   1 0 0 1   1 0 0 0   1 05
1 16000000 1 16000000   0 x x x   0 x x x   1 05
1 16000000 1 16000000   1 0 0 1   1 0 0 1   1 05
1 16000000 1 16000000   1 2 0 0   1 2 0 0   1 05
1 16000000 0 00000000   1 1 1 0   1 1 1 0   1 05
1 16000000 1 203005bb   1 1 1 0   0 x x x   1 05
1 16000000 1 16000000   1 1 1 0   0 x x x   1 05
1 16000000 1 16000000   1 1 1 0   1 1 1 0   1 05
1 1c800000 1 13800000   1 3 1 0   1 3 1 0   1 05
2 00000000 2 00000000   1 3 1 0   1 2 0 0   1 05
0 00000000 0 00000000   0 x x x   0 x x x   1 05
end
